// ==== rtl/expand_unit.sv ====
`timescale 1ns/1ps

module expand_unit import fire_pkg::*; #(
	parameter int PIXELS = 16
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	output wb_req_t rd_req,
	input  wb_rsp_t rd_rsp,
	output wb_req_t ofm_req,
	input  wb_rsp_t ofm_rsp,
	output logic    done
);

	localparam int PW = (PIXELS > 1) ? $clog2(PIXELS) : 1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD,
		S_W1,
		S_GAP,
		S_W3
	} state_t;

	state_t            state;
	logic [PW-1:0]     p;
	logic              tail; // writing the 3-tap of the last pixel
	logic              last_px;
	logic              tail_go;
	data_t             prev2;
	data_t             prev1;
	data_t             cur;
	acc_t              acc1;
	acc_t              acc3;
	logic [ADDR_W-1:0] base_adr;

	assign last_px = (p == PW'(PIXELS - 1));
	assign tail_go = ofm_rsp.ack && !tail && last_px &&
		((state == S_W1 && p == '0) || state == S_W3);
	assign base_adr = ADDR_W'(p) << 1;

	assign acc1 = acc_t'(EX1_W) * acc_t'(cur);
	assign acc3 = acc_t'(EX3_W[0]) * acc_t'(prev2) + acc_t'(EX3_W[1]) * acc_t'(prev1) +
		acc_t'(EX3_W[2]) * acc_t'(cur);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= S_IDLE;
			p <= '0;
			tail <= 1'b0;
			done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					p <= '0;
					tail <= 1'b0;
					done <= 1'b0;
					state <= S_RD;
				end
				S_RD: if (rd_rsp.ack)
					state <= S_W1;
				S_W1: if (ofm_rsp.ack) begin
					if (p != '0 || tail_go)
						state <= S_GAP; // 3-tap write follows
					else begin
						p <= p + 1'b1;
						state <= S_RD;
					end
					if (tail_go)
						tail <= 1'b1;
				end
				S_GAP: state <= S_W3;
				S_W3: if (ofm_rsp.ack) begin
					if (tail) begin
						done <= 1'b1;
						state <= S_IDLE;
					end else if (last_px) begin
						tail <= 1'b1;
						state <= S_GAP;
					end else begin
						p <= p + 1'b1;
						state <= S_RD;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// window slides on every read, and once more with a zero neighbour at the end
	always_ff @(posedge clk) begin
		if (state == S_IDLE && start) begin
			prev2 <= '0;
			prev1 <= '0;
			cur <= '0;
		end else if ((state == S_RD && rd_rsp.ack) || tail_go) begin
			prev2 <= prev1;
			prev1 <= cur;
			cur <= tail_go ? data_t'(0) : rd_rsp.dat;
		end
	end

	always_comb begin
		rd_req.cyc = (state == S_RD);
		rd_req.stb = (state == S_RD);
		rd_req.we = 1'b0;
		rd_req.adr = ADDR_W'(p);
		rd_req.dat = '0;
		ofm_req.cyc = (state == S_W1 || state == S_W3);
		ofm_req.stb = (state == S_W1 || state == S_W3);
		ofm_req.we = (state == S_W1 || state == S_W3);
		if (state == S_W1)
			ofm_req.adr = base_adr;
		else
			ofm_req.adr = tail ? base_adr + 1'b1 : base_adr - 1'b1;
		ofm_req.dat = (state == S_W1) ? quantize(acc1) : quantize(acc3);
	end

	a_ofm_range: assert property (@(posedge clk) disable iff (!rst)
		ofm_req.stb |-> ofm_req.adr < ADDR_W'(2 * PIXELS));

endmodule

// ==== rtl/fire_pkg.sv ====
package fire_pkg;

	typedef logic signed [15:0] data_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [31:0] acc_t;

	localparam int ADDR_W = 16;
	localparam int FRAC_SHIFT = 6;

	// one squeeze weight per input channel, room for 8 channels
	localparam weight_t SQ_W [8] = '{
		8'sd12,
		-8'sd7,
		8'sd20,
		8'sd5,
		-8'sd3,
		8'sd9,
		8'sd14,
		-8'sd11
	};

	localparam weight_t EX1_W = 8'sd18;

	// taps for previous, current and next pixel
	localparam weight_t EX3_W [3] = '{
		8'sd9,
		8'sd16,
		-8'sd5
	};

	// master side of a wishbone classic link
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		data_t             dat;
	} wb_req_t;

	// slave side
	typedef struct packed {
		logic  ack;
		data_t dat;
	} wb_rsp_t;

	// relu, scale down, saturate to the positive data_t range
	function automatic data_t quantize(input acc_t acc);
		acc_t sh;
		if (acc < 0)
			return '0;
		sh = acc >>> FRAC_SHIFT;
		if (sh > 32767)
			return 16'sd32767;
		return data_t'(sh);
	endfunction

endpackage

// ==== rtl/fire_top.sv ====
`timescale 1ns/1ps

module fire_top import fire_pkg::*; #(
	parameter int PIXELS = 16,
	parameter int IN_CH = 4,
	parameter int BUF_DEPTH = 4
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	output wb_req_t ifm_req,
	input  wb_rsp_t ifm_rsp,
	output wb_req_t ofm_req,
	input  wb_rsp_t ofm_rsp,
	output logic    done
);

	wb_req_t sq_req;
	wb_rsp_t sq_rsp;
	wb_req_t ex_req;
	wb_rsp_t ex_rsp;

	squeeze_unit #(
		.PIXELS(PIXELS),
		.IN_CH (IN_CH)
	) i_squeeze (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.ifm_req(ifm_req),
		.ifm_rsp(ifm_rsp),
		.sq_req (sq_req),
		.sq_rsp (sq_rsp)
	);

	fmap_buffer #(.BUF_DEPTH(BUF_DEPTH)) i_buffer (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.wr_req(sq_req),
		.wr_rsp(sq_rsp),
		.rd_req(ex_req),
		.rd_rsp(ex_rsp)
	);

	expand_unit #(.PIXELS(PIXELS)) i_expand (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.rd_req (ex_req),
		.rd_rsp (ex_rsp),
		.ofm_req(ofm_req),
		.ofm_rsp(ofm_rsp),
		.done   (done)
	);

endmodule

// ==== rtl/fmap_buffer.sv ====
`timescale 1ns/1ps

module fmap_buffer import fire_pkg::*; #(
	parameter int BUF_DEPTH = 4
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  wb_req_t wr_req,
	output wb_rsp_t wr_rsp,
	input  wb_req_t rd_req,
	output wb_rsp_t rd_rsp
);

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	data_t            store [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_ack;
	logic             rd_ack;
	data_t            rd_dat;
	logic             wr_go;
	logic             rd_go;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// accept only on a fresh strobe, never in the ack cycle itself
	assign wr_go = wr_req.cyc && wr_req.stb && wr_req.we && !wr_ack &&
		(count != CNT_W'(BUF_DEPTH));
	assign rd_go = rd_req.cyc && rd_req.stb && !rd_req.we && !rd_ack && (count != '0);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else if (start) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			wr_ack <= wr_go;
			rd_ack <= rd_go;
			if (wr_go)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_go)
				rd_ptr <= next_ptr(rd_ptr);
			case ({wr_go, rd_go})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go)
			store[wr_ptr] <= wr_req.dat;
		if (rd_go)
			rd_dat <= store[rd_ptr]; // lines up with rd_ack
	end

	assign wr_rsp.ack = wr_ack;
	assign wr_rsp.dat = '0;
	assign rd_rsp.ack = rd_ack;
	assign rd_rsp.dat = rd_dat;

	a_count_max: assert property (@(posedge clk) disable iff (!rst)
		count <= CNT_W'(BUF_DEPTH));

	a_ack_stb: assert property (@(posedge clk) disable iff (!rst)
		(!wr_rsp.ack || wr_req.stb) && (!rd_rsp.ack || rd_req.stb));

endmodule

// ==== rtl/squeeze_unit.sv ====
`timescale 1ns/1ps

module squeeze_unit import fire_pkg::*; #(
	parameter int PIXELS = 16,
	parameter int IN_CH = 4
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	output wb_req_t ifm_req,
	input  wb_rsp_t ifm_rsp,
	output wb_req_t sq_req,
	input  wb_rsp_t sq_rsp
);

	localparam int PW = (PIXELS > 1) ? $clog2(PIXELS) : 1;
	localparam int CW = (IN_CH > 1) ? $clog2(IN_CH) : 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RD,
		S_GAP,
		S_WR
	} state_t;

	state_t        state;
	logic [PW-1:0] p;
	logic [CW-1:0] c;
	acc_t          acc;
	acc_t          prod;

	assign prod = acc_t'(ifm_rsp.dat) * acc_t'(SQ_W[c]);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= S_IDLE;
			p <= '0;
			c <= '0;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					p <= '0;
					c <= '0;
					state <= S_RD;
				end
				S_RD: if (ifm_rsp.ack) begin
					if (c == CW'(IN_CH - 1))
						state <= S_WR; // all channels in, push the pixel
					else begin
						c <= c + 1'b1;
						state <= S_GAP;
					end
				end
				S_GAP: state <= S_RD; // idle cycle between reads
				S_WR: if (sq_rsp.ack) begin
					c <= '0;
					if (p == PW'(PIXELS - 1))
						state <= S_IDLE;
					else begin
						p <= p + 1'b1;
						state <= S_RD;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && start)
			acc <= '0;
		else if (state == S_WR && sq_rsp.ack)
			acc <= '0;
		else if (state == S_RD && ifm_rsp.ack)
			acc <= acc + prod;
	end

	always_comb begin
		ifm_req.cyc = (state == S_RD);
		ifm_req.stb = (state == S_RD);
		ifm_req.we = 1'b0;
		ifm_req.adr = ADDR_W'(p) * ADDR_W'(IN_CH) + ADDR_W'(c); // channel-major per pixel
		ifm_req.dat = '0;
		sq_req.cyc = (state == S_WR);
		sq_req.stb = (state == S_WR);
		sq_req.we = (state == S_WR);
		sq_req.adr = ADDR_W'(p);
		sq_req.dat = quantize(acc);
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst)
		!(ifm_req.stb && !ifm_req.cyc) && !(sq_req.stb && !sq_req.cyc));

	// a pending read keeps its address until the memory answers
	a_ifm_hold: assert property (@(posedge clk) disable iff (!rst)
		ifm_req.stb && !ifm_rsp.ack |=> ifm_req.stb && $stable(ifm_req.adr));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fire stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fire_tb \
	-f verilog.f -Mdir obj_dir -o fire_sim \
	&& ./obj_dir/fire_sim | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== sim/fire_tb.sv ====
`timescale 1ns/1ps

module fire_tb import fire_pkg::*;;

	localparam int PIXELS = 16;
	localparam int IN_CH = 4;
	localparam int BUF_DEPTH = 4;
	localparam int IFM_WORDS = PIXELS * IN_CH;
	localparam int OFM_WORDS = 2 * PIXELS;
	// 5 tests x 16 pixels x 6 accesses x 10 cycles, rounded up
	localparam int MAX_CYCLES = 6000;

	logic    clk;
	logic    rst;
	logic    start;
	logic    done;
	wb_req_t ifm_req;
	wb_rsp_t ifm_rsp;
	wb_req_t ofm_req;
	wb_rsp_t ofm_rsp;

	data_t in_mem [IFM_WORDS];
	data_t out_mem [OFM_WORDS];
	int    wr_cnt [OFM_WORDS];
	int    seed = 73;
	int    ifm_max;
	int    ofm_max;
	int    ofm_min;
	int    ifm_cnt;
	int    ofm_cnt;
	int    test_errs;
	int    pass_cnt;
	int    fail_cnt;
	int    cycles;

	fire_top #(
		.PIXELS   (PIXELS),
		.IN_CH    (IN_CH),
		.BUF_DEPTH(BUF_DEPTH)
	) i_dut (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.ifm_req(ifm_req),
		.ifm_rsp(ifm_rsp),
		.ofm_req(ofm_req),
		.ofm_rsp(ofm_rsp),
		.done   (done)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic int pick_wait(input int max_w);
		if (max_w == 0)
			return 0;
		return $unsigned($random(seed)) % (max_w + 1);
	endfunction

	// squeezed pixel, zero outside the line
	function automatic data_t sq_ref(input int p);
		acc_t acc;
		int   c;
		acc = 0;
		if (p < 0 || p >= PIXELS)
			return '0;
		for (c = 0; c < IN_CH; c++)
			acc += acc_t'(in_mem[p * IN_CH + c]) * acc_t'(SQ_W[c]);
		return quantize(acc);
	endfunction

	function automatic data_t expected_word(input int a);
		int   p;
		acc_t acc;
		p = a / 2;
		if (a % 2 == 0)
			acc = acc_t'(EX1_W) * acc_t'(sq_ref(p));
		else
			acc = acc_t'(EX3_W[0]) * acc_t'(sq_ref(p - 1)) +
				acc_t'(EX3_W[1]) * acc_t'(sq_ref(p)) + acc_t'(EX3_W[2]) * acc_t'(sq_ref(p + 1));
		return quantize(acc);
	endfunction

	// input memory, read only
	initial begin
		ifm_rsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (ifm_rsp.ack)
				ifm_rsp.ack = 1'b0; // one cycle ack
			else if (ifm_req.cyc && ifm_req.stb) begin
				if (ifm_cnt > 0)
					ifm_cnt--;
				else begin
					if (ifm_req.we || ifm_req.adr >= IFM_WORDS) begin
						$display("ERROR: bad input memory access at address %0d", ifm_req.adr);
						test_errs++;
					end
					ifm_rsp.dat = in_mem[ifm_req.adr % IFM_WORDS];
					ifm_rsp.ack = 1'b1;
					ifm_cnt = pick_wait(ifm_max);
				end
			end
		end
	end

	// output memory, write only
	initial begin
		ofm_rsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (ofm_rsp.ack)
				ofm_rsp.ack = 1'b0;
			else if (ofm_req.cyc && ofm_req.stb) begin
				if (ofm_cnt > 0)
					ofm_cnt--;
				else begin
					if (!ofm_req.we || ofm_req.adr >= OFM_WORDS) begin
						$display("ERROR: bad output memory access at address %0d", ofm_req.adr);
						test_errs++;
					end else begin
						out_mem[ofm_req.adr] = ofm_req.dat;
						wr_cnt[ofm_req.adr]++;
					end
					ofm_rsp.ack = 1'b1;
					ofm_cnt = ofm_min + pick_wait(ofm_max - ofm_min);
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: timeout after %0d cycles, done never came", cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic set_waits(input int in_w, input int out_w);
		ifm_max = in_w;
		ofm_max = out_w;
		ifm_cnt = pick_wait(in_w);
		ofm_cnt = pick_wait(out_w);
	endtask

	task automatic load_ramp(input int base, input int step);
		int a;
		for (a = 0; a < IFM_WORDS; a++)
			in_mem[a] = data_t'(base + step * a);
	endtask

	task automatic load_random();
		int a;
		for (a = 0; a < IFM_WORDS; a++)
			in_mem[a] = data_t'($random(seed));
	endtask

	task automatic run_frame(input string name);
		int a;
		for (a = 0; a < OFM_WORDS; a++) begin
			out_mem[a] = 'x;
			wr_cnt[a] = 0;
		end
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		if (done) begin
			$display("ERROR: %s, done still high after start", name);
			test_errs++;
		end
		while (!done) begin
			@(posedge clk);
			#1;
		end
		for (a = 0; a < OFM_WORDS; a++) begin
			if (wr_cnt[a] != 1) begin
				$display("ERROR: %s, output word %0d written %0d times", name, a, wr_cnt[a]);
				test_errs++;
			end
			if (out_mem[a] !== expected_word(a)) begin
				$display("CHECK FAILED %s word %0d: expected %0d, actual %0d", name, a,
					expected_word(a), out_mem[a]);
				test_errs++;
			end
		end
	endtask

	task automatic report(input string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// bus outputs and done stay quiet until the first start
	task automatic check_reset_state();
		logic [6:0] seen;
		repeat (5) begin
			@(posedge clk);
			#1;
			seen = {ifm_req.cyc, ifm_req.stb, ifm_req.we, ofm_req.cyc, ofm_req.stb,
				ofm_req.we, done};
			if (seen != 7'b0) begin
				$display("CHECK FAILED reset: expected 0000000, actual %b", seen);
				test_errs++;
			end
		end
		report("reset");
	endtask

	task automatic ramp_input();
		set_waits(0, 0);
		load_ramp(1, 1);
		run_frame("ramp");
		report("ramp");
	endtask

	task automatic random_input();
		set_waits(0, 0);
		load_random();
		run_frame("random");
		report("random");
	endtask

	task automatic slow_output();
		set_waits(1, 7); // output slower than input so the buffer fills
		ofm_min = 4;
		load_random();
		run_frame("backpressure");
		ofm_min = 0;
		set_waits(0, 0);
		report("backpressure");
	endtask

	task automatic back_to_back();
		set_waits(0, 2);
		load_ramp(300, -3);
		run_frame("back_to_back_1");
		load_random();
		run_frame("back_to_back_2");
		set_waits(0, 0);
		report("back_to_back");
	endtask

	initial begin
		rst = 1'b0;
		start = 1'b0;
		test_errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		ofm_min = 0;
		set_waits(0, 0);
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		check_reset_state();
		ramp_input();
		random_input();
		slow_output();
		back_to_back();
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/fire_pkg.sv
rtl/squeeze_unit.sv
rtl/fmap_buffer.sv
rtl/expand_unit.sv
rtl/fire_top.sv
sim/fire_tb.sv
